// File: design/exu_pkg.sv
`default_nettype none

package exu_pkg;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,     // branch compares give 0 or 1
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu,
    alu_pass_b, // lui, and csrrw with rs1 routed into b
    alu_andn    // csrrc: b & ~a
  } alu_op_e;

  typedef enum logic [1:0] {
    op2_src2,
    op2_imm,
    op2_csr
  } operand2_sel_e;

  typedef enum logic [2:0] {
    npc_seq,    // pc+4
    npc_jal,    // pc+imm
    npc_jalr,   // alu result, bit 0 cleared
    npc_branch, // pc+imm if alu bit 0
    npc_csr     // ecall and mret targets
  } npc_sel_e;

  typedef enum logic [2:0] {
    wdata_alu,
    wdata_link,
    wdata_auipc,
    wdata_load,
    wdata_csr   // old csr value
  } wdata_sel_e;

  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec = 12'h305;
  localparam csr_addr_t csr_mepc = 12'h341;
  localparam csr_addr_t csr_mcause = 12'h342;

  localparam logic [31:0] cause_ecall_m = 32'd11;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    alu_op_e alu_op;
    operand2_sel_e op2_sel;
    npc_sel_e npc_sel;
    wdata_sel_e wdata_sel;
    csr_addr_t csr_addr;  // mtvec for ecall, mepc for mret
    logic csr_write;
    logic ecall;
  } decoded_op_t;

  typedef struct packed {
    logic [31:0] npc;
    logic [31:0] alu_result;
    logic [31:0] rd_wdata;
  } exec_result_t;

  typedef struct packed {
    logic en;
    csr_addr_t addr;
    logic [31:0] data;
    logic trap;           // mepc <= epc, mcause <= cause
    logic [31:0] epc;
    logic [31:0] cause;
  } csr_write_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import exu_pkg::*; (
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result
);

  logic [4:0] shamt;
  logic eq;
  logic lt_s;
  logic lt_u;

  assign shamt = b[4:0];
  assign eq = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'b0, lt_s};
      alu_sltu:   result = {31'b0, lt_u};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_eq:     result = {31'b0, eq};
      alu_ne:     result = {31'b0, !eq};
      alu_lt:     result = {31'b0, lt_s};
      alu_ge:     result = {31'b0, !lt_s};
      alu_ltu:    result = {31'b0, lt_u};
      alu_geu:    result = {31'b0, !lt_u};
      alu_pass_b: result = b;
      alu_andn:   result = b & ~a;  // clear bits set in a
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file import exu_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  csr_addr_t   raddr,
  output logic [31:0] rdata,
  input  csr_write_t  wr
);

  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;

  // combinational read, unknown addresses give zero
  always_comb begin
    case (raddr)
      csr_mstatus: rdata = mstatus;
      csr_mtvec:   rdata = mtvec;
      csr_mepc:    rdata = mepc;
      csr_mcause:  rdata = mcause;
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= '0;
      mtvec   <= mtvec_reset;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wr.en) begin
        case (wr.addr)
          csr_mstatus: mstatus <= wr.data;
          csr_mtvec:   mtvec <= wr.data;
          csr_mepc:    mepc <= {wr.data[31:2], 2'b00};
          csr_mcause:  mcause <= wr.data;
          default:     ;  // ignored
        endcase
      end
      // trap update wins over a plain write
      if (wr.trap) begin
        mepc   <= {wr.epc[31:2], 2'b00};
        mcause <= wr.cause;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu import exu_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         op_valid,
  output logic         op_ready,
  input  decoded_op_t  op,
  output logic         res_valid,
  input  logic         res_ready,
  output exec_result_t res,
  output alu_op_e      alu_op,
  output logic [31:0]  alu_a,
  output logic [31:0]  alu_b,
  input  logic [31:0]  alu_result,
  output csr_addr_t    csr_raddr,
  input  logic [31:0]  csr_rdata,
  output logic [31:0]  mem_addr,
  input  logic [31:0]  mem_rdata,
  output csr_write_t   csr_wr
);

  // state captured at the input transfer
  typedef struct packed {
    alu_op_e alu_op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] snpc;
    logic [31:0] dnpc;
    logic [31:0] csr_val;
    logic [31:0] pc;
    npc_sel_e npc_sel;
    wdata_sel_e wdata_sel;
    csr_addr_t csr_addr;
    logic csr_write;
    logic ecall;
  } held_t;

  held_t held;
  logic in_fire;
  logic out_fire;
  logic [31:0] op2;
  logic [31:0] npc;
  logic [31:0] rd_wdata;

  assign in_fire = op_valid && op_ready;
  assign out_fire = res_valid && res_ready;

  assign csr_raddr = op.csr_addr;

  always_comb begin
    case (op.op2_sel)
      op2_src2: op2 = op.src2;
      op2_imm:  op2 = op.imm;
      op2_csr:  op2 = csr_rdata;  // csrrs, csrrc
      default:  op2 = '0;
    endcase
  end

  // one instruction in flight
  always_ff @(posedge clock) begin
    if (reset) begin
      op_ready  <= 1'b1;
      res_valid <= 1'b0;
    end else if (in_fire) begin
      op_ready  <= 1'b0;
      res_valid <= 1'b1;
    end else if (out_fire) begin
      op_ready  <= 1'b1;
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) begin
      held.alu_op    <= op.alu_op;
      held.a         <= op.src1;
      held.b         <= op2;
      held.snpc      <= op.pc + 32'd4;
      held.dnpc      <= op.pc + op.imm;
      held.csr_val   <= csr_rdata;
      held.pc        <= op.pc;
      held.npc_sel   <= op.npc_sel;
      held.wdata_sel <= op.wdata_sel;
      held.csr_addr  <= op.csr_addr;
      held.csr_write <= op.csr_write;
      held.ecall     <= op.ecall;
    end
  end

  assign alu_op = held.alu_op;
  assign alu_a = held.a;
  assign alu_b = held.b;

  always_comb begin
    case (held.npc_sel)
      npc_seq:    npc = held.snpc;
      npc_jal:    npc = held.dnpc;
      npc_jalr:   npc = {alu_result[31:1], 1'b0};
      npc_branch: npc = alu_result[0] ? held.dnpc : held.snpc;
      npc_csr:    npc = held.csr_val;  // mtvec or mepc
      default:    npc = held.snpc;
    endcase
  end

  always_comb begin
    case (held.wdata_sel)
      wdata_alu:   rd_wdata = alu_result;
      wdata_link:  rd_wdata = held.snpc;
      wdata_auipc: rd_wdata = held.dnpc;
      wdata_load:  rd_wdata = mem_rdata;
      wdata_csr:   rd_wdata = held.csr_val;
      default:     rd_wdata = alu_result;
    endcase
  end

  assign res.npc = npc;
  assign res.alu_result = alu_result;
  assign res.rd_wdata = rd_wdata;

  assign mem_addr = alu_result;

  // csr side effects commit with the output transfer
  assign csr_wr.en = out_fire && held.csr_write;
  assign csr_wr.addr = held.csr_addr;
  assign csr_wr.data = alu_result;
  assign csr_wr.trap = out_fire && held.ecall;
  assign csr_wr.epc = held.pc;
  assign csr_wr.cause = cause_ecall_m;

endmodule

`default_nettype wire

// File: design/exec_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module exec_subsystem import exu_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h8000_0000
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         op_valid,
  output logic         op_ready,
  input  decoded_op_t  op,
  output logic         res_valid,
  input  logic         res_ready,
  output exec_result_t res,
  output logic [31:0]  mem_addr,
  input  logic [31:0]  mem_rdata
);

  alu_op_e alu_op;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  csr_addr_t csr_raddr;
  logic [31:0] csr_rdata;
  csr_write_t csr_wr;

  exu exu0 (
    .clock      (clock),
    .reset      (reset),
    .op_valid   (op_valid),
    .op_ready   (op_ready),
    .op         (op),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res        (res),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata),
    .csr_wr     (csr_wr)
  );

  alu alu0 (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  csr_file #(
    .mtvec_reset (mtvec_reset)
  ) csr0 (
    .clock (clock),
    .reset (reset),
    .raddr (csr_raddr),
    .rdata (csr_rdata),
    .wr    (csr_wr)
  );

endmodule

`default_nettype wire

// File: dv/exec_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exec_subsystem_properties import exu_pkg::*; (
  input logic         clock,
  input logic         reset,
  input logic         op_ready,
  input logic         res_valid,
  input logic         res_ready,
  input exec_result_t res,
  input csr_write_t   csr_wr
);

  // result must hold until the consumer takes it
  assert property (@(posedge clock) disable iff (reset)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else $error("res_valid or res changed before the output transfer");

  assert property (@(posedge clock) disable iff (reset)
    !(op_ready && res_valid))
    else $error("op_ready and res_valid high together");

  assert property (@(posedge clock) disable iff (reset)
    csr_wr.en |-> res_valid && res_ready)
    else $error("csr write enable without an output transfer");

endmodule

bind exu exec_subsystem_properties props0 (
  .clock     (clock),
  .reset     (reset),
  .op_ready  (op_ready),
  .res_valid (res_valid),
  .res_ready (res_ready),
  .res       (res),
  .csr_wr    (csr_wr)
);

`default_nettype wire

// File: dv/exec_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_subsystem_tb import exu_pkg::*; ();

  localparam int clk_period = 40;
  localparam int n_alu = 36;
  localparam int n_ctrl = 21;
  localparam int n_load = 8;
  localparam int n_csr = 12;
  localparam int n_trap = 7;
  localparam int n_bp = 30;
  localparam int n_total = n_alu + n_ctrl + n_load + n_csr + n_trap + n_bp;
  localparam int watchdog_cycles = n_total * 60 + 8;

  logic clock;
  logic reset;
  logic op_valid;
  logic op_ready;
  decoded_op_t op;
  logic res_valid;
  logic res_ready;
  exec_result_t res;
  logic [31:0] mem_addr;
  logic [31:0] mem_rdata;

  integer seed = 90319;
  logic throttle = 1'b0;
  decoded_op_t pending[$];
  int n_issued = 0;
  int n_results = 0;
  int n_errors = 0;
  int n_tests = 0;
  logic [31:0] m_mstatus = '0;  // model csrs
  logic [31:0] m_mtvec = 32'h8000_0100;
  logic [31:0] m_mepc = '0;
  logic [31:0] m_mcause = '0;

  exec_subsystem #(.mtvec_reset(32'h8000_0100)) dut0 (
    .clock     (clock),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op        (op),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata)
  );

  function automatic logic [31:0] mem_hash(input logic [31:0] a);
    return ((a ^ 32'h5bd1_e995) * 32'h0100_0193) ^ {a[12:0], a[31:13]};
  endfunction

  assign mem_rdata = mem_hash(mem_addr);  // memory model

  function automatic logic [31:0] alu_model(input alu_op_e f, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (f)
      alu_add:    return a + b;
      alu_sub:    return a + ~b + 1;
      alu_sll:    return a << b[4:0];
      alu_slt:    return 32'($signed(a) < $signed(b));
      alu_sltu:   return 32'(a < b);
      alu_xor:    return a ^ b;
      alu_srl:    return a >> b[4:0];
      alu_sra:    return ext[31:0];
      alu_or:     return a | b;
      alu_and:    return a & b;
      alu_eq:     return 32'(a == b);
      alu_ne:     return 32'(a != b);
      alu_lt:     return 32'($signed(a) < $signed(b));
      alu_ge:     return 32'($signed(a) >= $signed(b));
      alu_ltu:    return 32'(a < b);
      alu_geu:    return 32'(a >= b);
      alu_pass_b: return b;
      alu_andn:   return b & ~a;
      default:    return '0;
    endcase
  endfunction

  function automatic logic [31:0] csr_model_read(input csr_addr_t a);
    case (a)
      csr_mstatus: return m_mstatus;
      csr_mtvec:   return m_mtvec;
      csr_mepc:    return m_mepc;
      csr_mcause:  return m_mcause;
      default:     return '0;
    endcase
  endfunction

  function automatic exec_result_t expect_result(input decoded_op_t o);
    exec_result_t r;
    logic [31:0] csr_val;
    logic [31:0] b;
    csr_val = csr_model_read(o.csr_addr);
    b = (o.op2_sel == op2_imm) ? o.imm : (o.op2_sel == op2_csr) ? csr_val : o.src2;
    r.alu_result = alu_model(o.alu_op, o.src1, b);
    case (o.npc_sel)
      npc_jal:    r.npc = o.pc + o.imm;
      npc_jalr:   r.npc = r.alu_result & 32'hffff_fffe;
      npc_branch: r.npc = r.alu_result[0] ? o.pc + o.imm : o.pc + 4;
      npc_csr:    r.npc = csr_val;
      default:    r.npc = o.pc + 4;
    endcase
    case (o.wdata_sel)
      wdata_link:  r.rd_wdata = o.pc + 4;
      wdata_auipc: r.rd_wdata = o.pc + o.imm;
      wdata_load:  r.rd_wdata = mem_hash(r.alu_result);
      wdata_csr:   r.rd_wdata = csr_val;
      default:     r.rd_wdata = r.alu_result;
    endcase
    return r;
  endfunction

  task automatic commit_csr(input decoded_op_t o, input logic [31:0] data);
    if (o.csr_write) begin
      case (o.csr_addr)
        csr_mstatus: m_mstatus = data;
        csr_mtvec:   m_mtvec = data;
        csr_mepc:    m_mepc = data & 32'hffff_fffc;
        csr_mcause:  m_mcause = data;
        default:     ;
      endcase
    end
    if (o.ecall) begin
      m_mepc = o.pc & 32'hffff_fffc;
      m_mcause = 32'd11;
    end
  endtask

  task automatic check_result(input exec_result_t got, input exec_result_t exp);
    if (got.npc !== exp.npc) begin
      $display("error: res.npc got %h expected %h", got.npc, exp.npc);
      n_errors++;
    end
    if (got.alu_result !== exp.alu_result) begin
      $display("error: res.alu_result got %h expected %h", got.alu_result, exp.alu_result);
      n_errors++;
    end
    if (got.rd_wdata !== exp.rd_wdata) begin
      $display("error: res.rd_wdata got %h expected %h", got.rd_wdata, exp.rd_wdata);
      n_errors++;
    end
  endtask

  task automatic check_csr(input csr_addr_t a, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: csr[%h] got %h expected %h", a, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_mem_addr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: mem_addr got %h expected %h", got, exp);
      n_errors++;
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // random back-pressure only while throttled
  always @(posedge clock) begin
    #2;
    res_ready = throttle ? (($random(seed) % 3) != 0) : 1'b1;
  end

  always @(negedge clock) begin : compare
    decoded_op_t o;
    exec_result_t exp;
    if (reset === 1'b0 && res_valid === 1'b1 && res_ready === 1'b1) begin
      if (pending.size() == 0) begin
        $display("a result came out with no instruction outstanding");
        n_errors++;
      end else begin
        o = pending.pop_front();
        exp = expect_result(o);
        check_result(res, exp);
        check_mem_addr(mem_addr, exp.alu_result);
        if (o.alu_op == alu_or && o.op2_sel == op2_csr && o.src1 == 0 && !o.csr_write)
          check_csr(o.csr_addr, res.rd_wdata, csr_model_read(o.csr_addr));
        commit_csr(o, exp.alu_result);
        n_results++;
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout after %0d cycles, %0d of %0d results seen",
             watchdog_cycles, n_results, n_issued);
    $display("TB FAILED");
    $finish;
  end

  function automatic decoded_op_t blank_op();
    decoded_op_t o;
    o = '0;
    o.pc = $random(seed) & 32'hffff_fffc;
    o.alu_op = alu_add;
    o.op2_sel = op2_src2;
    o.npc_sel = npc_seq;
    o.wdata_sel = wdata_alu;
    return o;
  endfunction

  task automatic issue(input decoded_op_t o);
    op = o;
    op_valid = 1'b1;
    while (op_ready !== 1'b1) begin
      @(posedge clock);
      #2;
    end
    @(posedge clock);  // input transfer
    pending.push_back(o);
    n_issued++;
    #2;
    op_valid = 1'b0;
  endtask

  task automatic csr_access(input alu_op_e f, input csr_addr_t a, input logic [31:0] v,
                            input logic write);
    decoded_op_t o;
    o = blank_op();
    o.alu_op = f;
    o.src1 = v;
    o.src2 = v;  // csrrw takes rs1 through b
    o.op2_sel = (f == alu_pass_b) ? op2_src2 : op2_csr;
    o.wdata_sel = wdata_csr;
    o.csr_addr = a;
    o.csr_write = write;
    issue(o);
  endtask

  task automatic trap_op(input logic is_ecall);
    decoded_op_t o;
    o = blank_op();
    o.npc_sel = npc_csr;
    o.csr_addr = is_ecall ? csr_mtvec : csr_mepc;
    o.ecall = is_ecall;
    issue(o);
  endtask

  task automatic end_test(input string name, input int err_before, input int res_before);
    wait (n_results == n_issued);
    @(posedge clock);
    #2;
    $display("test %s: %0d results, %0d errors", name, n_results - res_before,
             n_errors - err_before);
    n_tests++;
  endtask

  initial begin
    decoded_op_t o;
    int e0;
    int r0;
    logic [31:0] pair_a[3];
    logic [31:0] pair_b[3];
    pair_a = '{32'd5, 32'hffff_fffd, 32'd7};
    pair_b = '{32'd5, 32'd7, 32'hffff_fffd};
    reset = 1'b1;
    op_valid = 1'b0;
    op = '0;
    res_ready = 1'b0;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;

    e0 = n_errors;
    r0 = n_results;
    for (int i = 0; i < n_alu; i++) begin
      o = blank_op();
      o.alu_op = alu_op_e'(i % 18);
      o.src1 = $random(seed);
      o.src2 = $random(seed);
      o.imm = $random(seed);
      o.op2_sel = (i >= 18) ? op2_imm : op2_src2;
      issue(o);
    end
    end_test("alu", e0, r0);

    e0 = n_errors;
    r0 = n_results;
    o = blank_op();
    o.imm = 32'h0000_0a40;
    o.npc_sel = npc_jal;
    o.wdata_sel = wdata_link;
    issue(o);
    o = blank_op();
    o.src1 = 32'h0000_2001;  // odd target
    o.imm = 32'h10;
    o.op2_sel = op2_imm;
    o.npc_sel = npc_jalr;
    o.wdata_sel = wdata_link;
    issue(o);
    o = blank_op();
    o.imm = 32'hfff0_1000;
    o.wdata_sel = wdata_auipc;
    issue(o);
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        o = blank_op();
        o.alu_op = alu_op_e'(int'(alu_eq) + k);
        o.src1 = pair_a[p];
        o.src2 = pair_b[p];
        o.imm = 32'hffff_ff80;
        o.npc_sel = npc_branch;
        issue(o);
      end
    end
    end_test("control", e0, r0);

    e0 = n_errors;
    r0 = n_results;
    for (int i = 0; i < n_load; i++) begin
      o = blank_op();
      o.src1 = $random(seed);
      o.imm = i * 4;
      o.op2_sel = op2_imm;
      o.wdata_sel = wdata_load;
      issue(o);
    end
    end_test("load", e0, r0);

    e0 = n_errors;
    r0 = n_results;
    csr_access(alu_or, csr_mstatus, 0, 1'b0);
    csr_access(alu_pass_b, csr_mstatus, 32'h0000_1888, 1'b1);
    csr_access(alu_or, csr_mstatus, 0, 1'b0);
    csr_access(alu_or, csr_mstatus, 32'h0000_0006, 1'b1);
    csr_access(alu_or, csr_mstatus, 0, 1'b0);
    csr_access(alu_andn, csr_mstatus, 32'h0000_1800, 1'b1);
    csr_access(alu_or, csr_mstatus, 0, 1'b0);
    csr_access(alu_or, 12'h340, 0, 1'b0);  // not implemented
    csr_access(alu_pass_b, 12'h340, 32'hdead_0001, 1'b1);
    csr_access(alu_or, 12'h340, 0, 1'b0);
    csr_access(alu_pass_b, csr_mepc, 32'h0000_1003, 1'b1);
    csr_access(alu_or, csr_mepc, 0, 1'b0);
    end_test("csr", e0, r0);

    e0 = n_errors;
    r0 = n_results;
    trap_op(1'b1);
    csr_access(alu_or, csr_mepc, 0, 1'b0);
    csr_access(alu_or, csr_mcause, 0, 1'b0);
    trap_op(1'b0);
    csr_access(alu_pass_b, csr_mtvec, 32'h8000_0200, 1'b1);
    trap_op(1'b1);
    trap_op(1'b0);
    end_test("trap", e0, r0);

    e0 = n_errors;
    r0 = n_results;
    throttle = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      o = blank_op();
      o.alu_op = alu_op_e'($unsigned($random(seed)) % 18);
      o.src1 = $random(seed);
      o.src2 = $random(seed);
      o.imm = $random(seed);
      o.op2_sel = operand2_sel_e'($unsigned($random(seed)) % 2);
      o.npc_sel = npc_sel_e'($unsigned($random(seed)) % 4);
      o.wdata_sel = wdata_sel_e'($unsigned($random(seed)) % 4);
      issue(o);
    end
    end_test("backpressure", e0, r0);
    throttle = 1'b0;

    if (n_results != n_issued) begin
      $display("%0d instructions issued but %0d results seen", n_issued, n_results);
      n_errors++;
    end
    $display("%0d tests, %0d issued, %0d results, %0d errors", n_tests, n_issued,
             n_results, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/exu_pkg.sv
design/alu.sv
design/csr_file.sv
design/exu.sv
design/exec_subsystem.sv
dv/exec_subsystem_properties.sv
dv/exec_subsystem_tb.sv

// File: Bender.yml
package:
  name: exec_subsystem

sources:
  - files:
      - design/exu_pkg.sv
      - design/alu.sv
      - design/csr_file.sv
      - design/exu.sv
      - design/exec_subsystem.sv

  - target: test
    files:
      - dv/exec_subsystem_properties.sv
      - dv/exec_subsystem_tb.sv
